/* common/acc_pkg.sv */
// ******************************
// Accelerator package
// Register map, FSM states and bus structs
// ******************************
package acc_pkg;

  localparam int MEM_AW = 8;
  localparam int DW     = 32;
  localparam int REG_AW = 4;

  // Register map, word indices
  localparam int REG_INPUT_PTR   = 0;
  localparam int REG_WEIGHT_PTR0 = 1;
  localparam int REG_WEIGHT_PTR1 = 2;
  localparam int REG_OUTPUT_PTR  = 3;
  localparam int REG_LEN         = 4;
  localparam int REG_REQUANT     = 5; // mult 7:0, shift 15:8, add 23:16
  localparam int REG_CTRL        = 6; // bit 0 nextload, bit 1 output disable
  localparam int REG_TRIGGER     = 7;
  localparam int REG_STATUS      = 8; // bit 0 busy
  localparam int N_CFG_REGS      = REG_CTRL + 1;

  // Arbiter ports, lowest index wins
  localparam int N_REQ       = 4;
  localparam int PORT_W      = $clog2(N_REQ);
  localparam int PORT_HOST   = 0;
  localparam int PORT_SINK   = 1;
  localparam int PORT_WEIGHT = 2;
  localparam int PORT_INPUT  = 3;

  typedef enum logic [2:0] {IDLE, PASS0, RELOAD, PASS1, DRAIN} ctrl_state_e;

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [REG_AW-1:0] addr;
    logic [DW-1:0]     wdata;
  } cfg_req_t;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [DW-1:0]     wdata;
  } mem_req_t;

  typedef struct packed {
    logic [MEM_AW-1:0] base;
    logic [MEM_AW-1:0] len;
    logic              start;
  } stream_cfg_t;

  typedef struct packed {
    logic [7:0] mult;
    logic [7:0] shift;
    logic [7:0] add;
  } requant_t;

  typedef struct packed {
    logic [MEM_AW-1:0] in_ptr;
    logic [MEM_AW-1:0] w_ptr0;
    logic [MEM_AW-1:0] w_ptr1;
    logic [MEM_AW-1:0] out_ptr;
    logic [MEM_AW-1:0] len;
    requant_t          rq;
    logic              nextload;
    logic              out_disable;
  } job_cfg_t;

endpackage

/* design/ctrl/acc_regfile.sv */
// ******************************
// Config register file
// Host writes, trigger strobe, status readback
// ******************************
`timescale 1ns/1ps

module acc_regfile (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  acc_pkg::cfg_req_t cfg_req_i,
  output logic [31:0]       cfg_rdata_o,
  input  logic              busy_i,
  output acc_pkg::job_cfg_t job_o,
  output logic              start_o
);
  import acc_pkg::*;

  logic [DW-1:0] regs_q [N_CFG_REGS];
  logic [DW-1:0] rdata_d;
  logic          cfg_wr;
  logic          cfg_hit;

  assign cfg_wr  = cfg_req_i.valid && cfg_req_i.we;
  assign cfg_hit = int'(cfg_req_i.addr) < N_CFG_REGS;

  // Trigger while busy is dropped
  assign start_o = cfg_wr && (cfg_req_i.addr == REG_AW'(REG_TRIGGER)) && !busy_i;

  always_comb begin
    rdata_d = '0;
    if (cfg_req_i.addr == REG_AW'(REG_STATUS)) begin
      rdata_d = {31'b0, busy_i};
    end else if (cfg_hit) begin
      rdata_d = regs_q[cfg_req_i.addr[2:0]];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q      <= '{default: '0};
      cfg_rdata_o <= '0;
    end else if (cfg_req_i.valid) begin
      if (!cfg_req_i.we) cfg_rdata_o <= rdata_d;
      else if (cfg_hit) regs_q[cfg_req_i.addr[2:0]] <= cfg_req_i.wdata;
    end
  end

  always_comb begin
    job_o.in_ptr      = regs_q[REG_INPUT_PTR][MEM_AW-1:0];
    job_o.w_ptr0      = regs_q[REG_WEIGHT_PTR0][MEM_AW-1:0];
    job_o.w_ptr1      = regs_q[REG_WEIGHT_PTR1][MEM_AW-1:0];
    job_o.out_ptr     = regs_q[REG_OUTPUT_PTR][MEM_AW-1:0];
    job_o.len         = regs_q[REG_LEN][MEM_AW-1:0];
    if (job_o.len == '0) job_o.len = MEM_AW'(1); // Zero length runs one element
    job_o.rq.mult     = regs_q[REG_REQUANT][7:0];
    job_o.rq.shift    = regs_q[REG_REQUANT][15:8];
    job_o.rq.add      = regs_q[REG_REQUANT][23:16];
    job_o.nextload    = regs_q[REG_CTRL][0];
    job_o.out_disable = regs_q[REG_CTRL][1];
  end

endmodule

/* design/ctrl/acc_ctrl.sv */
// ******************************
// Job sequencer
// Starts the streams, optional weight reload pass
// ******************************
`timescale 1ns/1ps

module acc_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  acc_pkg::job_cfg_t    job_i,
  input  logic                 in_done_i,
  input  logic                 w_done_i,
  input  logic                 sink_idle_i,
  output acc_pkg::stream_cfg_t in_cfg_o,
  output acc_pkg::stream_cfg_t w_cfg_o,
  output logic                 pass_o,
  output logic                 busy_o,
  output logic                 done_o
);
  import acc_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        pass_q, pass_d;
  logic        all_idle;
  logic        kick;

  assign all_idle = in_done_i && w_done_i && sink_idle_i;
  assign kick     = (state_q == IDLE && start_i) || state_q == RELOAD;

  always_comb begin
    state_d = state_q;
    pass_d  = pass_q;
    done_o  = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = PASS0;
          pass_d  = 1'b0;
        end
      end
      PASS0: begin
        if (!job_i.nextload) state_d = DRAIN;
        else if (all_idle) state_d = RELOAD;
      end
      RELOAD: begin
        state_d = PASS1; // Second weight set, outputs shifted by len
        pass_d  = 1'b1;
      end
      PASS1: state_d = DRAIN;
      DRAIN: begin
        if (all_idle) begin
          state_d = IDLE;
          done_o  = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    in_cfg_o.base  = job_i.in_ptr;
    in_cfg_o.len   = job_i.len;
    in_cfg_o.start = kick;
    w_cfg_o.base   = (state_q == RELOAD) ? job_i.w_ptr1 : job_i.w_ptr0;
    w_cfg_o.len    = job_i.len;
    w_cfg_o.start  = kick;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      pass_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      pass_q  <= pass_d;
    end
  end

  assign pass_o = pass_q;
  assign busy_o = state_q != IDLE;

endmodule

/* design/stream/stream_source.sv */
// ******************************
// Read stream source
// Linear fetch into a one-word holding register
// ******************************
`timescale 1ns/1ps

module stream_source (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  acc_pkg::stream_cfg_t cfg_i,
  output acc_pkg::mem_req_t    mem_o,
  input  logic                 gnt_i,
  input  logic                 rvalid_i,
  input  logic [31:0]          rdata_i,
  output logic [31:0]          data_o,
  output logic                 valid_o,
  input  logic                 pop_i,
  output logic                 done_o
);
  import acc_pkg::*;

  logic [MEM_AW-1:0] addr_q;
  logic [MEM_AW-1:0] remain_q;
  logic              inflight_q;
  logic              full_q;
  logic [DW-1:0]     data_q;

  // Request stays up until granted
  always_comb begin
    mem_o       = '0;
    mem_o.req   = (remain_q != '0) && !full_q && !inflight_q;
    mem_o.addr  = addr_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q     <= '0;
      remain_q   <= '0;
      inflight_q <= 1'b0;
      full_q     <= 1'b0;
    end else begin
      if (cfg_i.start) begin
        addr_q   <= cfg_i.base;
        remain_q <= cfg_i.len;
      end else if (gnt_i) begin
        addr_q   <= addr_q + MEM_AW'(1);
        remain_q <= remain_q - MEM_AW'(1);
      end
      if (gnt_i) inflight_q <= 1'b1;
      else if (rvalid_i) inflight_q <= 1'b0;
      if (rvalid_i) full_q <= 1'b1;
      else if (pop_i) full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvalid_i) data_q <= rdata_i;
  end

  assign data_o  = data_q;
  assign valid_o = full_q;
  assign done_o  = (remain_q == '0) && !inflight_q && !full_q;

endmodule

/* design/mem_arbiter.sv */
// ******************************
// Scratch memory arbiter
// Fixed priority, read data steered back
// ******************************
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  acc_pkg::mem_req_t [acc_pkg::N_REQ-1:0] req_i,
  output logic [acc_pkg::N_REQ-1:0]               gnt_o,
  output logic [acc_pkg::N_REQ-1:0]               rvalid_o,
  output logic [31:0]                             rdata_o,
  output acc_pkg::mem_req_t                       mem_o,
  input  logic [31:0]                             mem_rdata_i
);
  import acc_pkg::*;

  logic [PORT_W-1:0] sel;
  logic [PORT_W-1:0] rd_sel_q;
  logic              rd_valid_q;

  // Walk down so the lowest requesting index wins
  always_comb begin
    gnt_o = '0;
    sel   = '0;
    for (int i = N_REQ - 1; i >= 0; i--) begin
      if (req_i[i].req) begin
        gnt_o    = '0;
        gnt_o[i] = 1'b1;
        sel      = PORT_W'(i);
      end
    end
  end

  always_comb begin
    mem_o     = req_i[sel];
    mem_o.req = |gnt_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_sel_q   <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_sel_q   <= sel;
      rd_valid_q <= mem_o.req && !mem_o.we;
    end
  end

  assign rvalid_o = rd_valid_q ? (N_REQ'(1) << rd_sel_q) : '0;
  assign rdata_o  = mem_rdata_i;

endmodule

/* design/scratch_mem.sv */
// ******************************
// Scratch memory
// 256x32 single port, synchronous
// ******************************
`timescale 1ns/1ps

module scratch_mem (
  input  logic              clk_i,
  input  acc_pkg::mem_req_t req_i,
  output logic [31:0]       rdata_o
);
  import acc_pkg::*;

  logic [DW-1:0] mem_q [2**MEM_AW];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) mem_q[req_i.addr] <= req_i.wdata;
      else rdata_o <= mem_q[req_i.addr]; // Valid the cycle after grant
    end
  end

endmodule

/* design/requant_engine.sv */
// ******************************
// Requantization engine
// int8 multiply, rescale, saturate, write back
// ******************************
`timescale 1ns/1ps

module requant_engine (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  acc_pkg::job_cfg_t job_i,
  input  logic              pass_i,
  input  logic [31:0]       in_data_i,
  input  logic              in_valid_i,
  input  logic [31:0]       w_data_i,
  input  logic              w_valid_i,
  output logic              in_pop_o,
  output logic              w_pop_o,
  output acc_pkg::mem_req_t mem_o,
  input  logic              gnt_i,
  output logic              idle_o
);
  import acc_pkg::*;

  logic signed [15:0] prod;
  logic signed [23:0] scaled;
  logic signed [23:0] shifted;
  logic signed [24:0] summed;
  logic        [7:0]  sat;
  logic               fire;
  logic [MEM_AW-1:0]  idx_q;
  logic [MEM_AW-1:0]  out_addr;
  logic               pend_q;
  logic [MEM_AW-1:0]  addr_q;
  logic [DW-1:0]      data_q;

  assign fire     = in_valid_i && w_valid_i && !pend_q;
  assign in_pop_o = fire;
  assign w_pop_o  = fire;

  assign prod    = $signed(in_data_i[7:0]) * $signed(w_data_i[7:0]);
  assign scaled  = prod * $signed(job_i.rq.mult);
  assign shifted = scaled >>> job_i.rq.shift;
  assign summed  = shifted + $signed(job_i.rq.add);

  always_comb begin
    if (summed > 25'sd127) sat = 8'h7f;
    else if (summed < -25'sd128) sat = 8'h80;
    else sat = summed[7:0];
  end

  // Second pass lands right after the first pass results
  assign out_addr = job_i.out_ptr + idx_q + (pass_i ? job_i.len : '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q  <= '0;
      pend_q <= 1'b0;
    end else begin
      if (fire) idx_q <= (idx_q == job_i.len - MEM_AW'(1)) ? '0 : idx_q + MEM_AW'(1);
      if (fire && !job_i.out_disable) pend_q <= 1'b1;
      else if (gnt_i) pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      addr_q <= out_addr;
      data_q <= {{24{sat[7]}}, sat};
    end
  end

  always_comb begin
    mem_o.req   = pend_q;
    mem_o.we    = 1'b1;
    mem_o.addr  = addr_q;
    mem_o.wdata = data_q;
  end

  assign idle_o = !pend_q;

endmodule

/* design/acc_top.sv */
// ******************************
// Accelerator top level
// ******************************
`timescale 1ns/1ps

module acc_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  acc_pkg::cfg_req_t cfg_req_i,
  output logic [31:0]       cfg_rdata_o,
  input  acc_pkg::mem_req_t host_mem_i,
  output logic [31:0]       host_rdata_o,
  output logic              busy_o,
  output logic              done_o
);
  import acc_pkg::*;

  job_cfg_t              job;
  logic                  start;
  stream_cfg_t           in_cfg, w_cfg;
  logic                  pass;
  logic                  in_done, w_done, sink_idle;
  mem_req_t [N_REQ-1:0]  arb_req;
  logic     [N_REQ-1:0]  gnt, rvalid;
  logic     [DW-1:0]     arb_rdata;
  mem_req_t              mem_req;
  logic     [DW-1:0]     mem_rdata;
  logic     [DW-1:0]     in_data, w_data;
  logic                  in_valid, w_valid, in_pop, w_pop;

  assign arb_req[PORT_HOST] = host_mem_i;
  assign host_rdata_o = rvalid[PORT_HOST] ? arb_rdata : '0;

  acc_regfile i_regfile (
    .clk_i, .rst_ni, .cfg_req_i, .cfg_rdata_o,
    .busy_i(busy_o), .job_o(job), .start_o(start)
  );

  acc_ctrl i_ctrl (
    .clk_i, .rst_ni, .start_i(start), .job_i(job),
    .in_done_i(in_done), .w_done_i(w_done), .sink_idle_i(sink_idle),
    .in_cfg_o(in_cfg), .w_cfg_o(w_cfg), .pass_o(pass), .busy_o, .done_o
  );

  stream_source i_in_source (
    .clk_i, .rst_ni, .cfg_i(in_cfg), .mem_o(arb_req[PORT_INPUT]),
    .gnt_i(gnt[PORT_INPUT]), .rvalid_i(rvalid[PORT_INPUT]), .rdata_i(arb_rdata),
    .data_o(in_data), .valid_o(in_valid), .pop_i(in_pop), .done_o(in_done)
  );

  stream_source i_w_source (
    .clk_i, .rst_ni, .cfg_i(w_cfg), .mem_o(arb_req[PORT_WEIGHT]),
    .gnt_i(gnt[PORT_WEIGHT]), .rvalid_i(rvalid[PORT_WEIGHT]), .rdata_i(arb_rdata),
    .data_o(w_data), .valid_o(w_valid), .pop_i(w_pop), .done_o(w_done)
  );

  requant_engine i_engine (
    .clk_i, .rst_ni, .job_i(job), .pass_i(pass),
    .in_data_i(in_data), .in_valid_i(in_valid), .w_data_i(w_data), .w_valid_i(w_valid),
    .in_pop_o(in_pop), .w_pop_o(w_pop), .mem_o(arb_req[PORT_SINK]),
    .gnt_i(gnt[PORT_SINK]), .idle_o(sink_idle)
  );

  mem_arbiter i_arbiter (
    .clk_i, .rst_ni, .req_i(arb_req), .gnt_o(gnt), .rvalid_o(rvalid),
    .rdata_o(arb_rdata), .mem_o(mem_req), .mem_rdata_i(mem_rdata)
  );

  scratch_mem i_mem (.clk_i, .req_i(mem_req), .rdata_o(mem_rdata));

endmodule

/* testbench/acc_props.sv */
// ******************************
// Accelerator assertions
// Grant, done and busy protocol
// ******************************
`timescale 1ns/1ps

module acc_props (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic [acc_pkg::N_REQ-1:0] gnt_i,
  input acc_pkg::cfg_req_t         cfg_req_i,
  input logic                      busy_i,
  input logic                      done_i
);
  import acc_pkg::*;

  logic trigger;

  assign trigger = cfg_req_i.valid && cfg_req_i.we && cfg_req_i.addr == REG_AW'(REG_TRIGGER);

  gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_i))
    else $error("arbiter grant is not one-hot");

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i && !busy_i)
    else $error("done_o held past one cycle or busy_o still high");

  busy_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trigger && !busy_i |=> busy_i)
    else $error("busy_o did not rise after the trigger write");

endmodule

// Grant comes from the arbiter inside the top level
bind acc_top acc_props i_acc_props (
  .clk_i, .rst_ni, .gnt_i(gnt), .cfg_req_i, .busy_i(busy_o), .done_i(done_o)
);

/* testbench/acc_tb.sv */
// ******************************
// Accelerator testbench
// Table of jobs, host model and checker
// ******************************
`timescale 1ns/1ps

module acc_tb;
  import acc_pkg::*;

  typedef struct packed {
    logic [7:0] in_ptr;
    logic [7:0] w_ptr0;
    logic [7:0] w_ptr1;
    logic [7:0] out_ptr;
    logic [7:0] len;
    logic [7:0] mult;
    logic [7:0] shift;
    logic [7:0] add;
    logic       nextload;
    logic       out_disable;
    logic       poke; // Status probe and host write mid-job
  } job_t;

  localparam int         N_JOBS    = 6;
  localparam logic [7:0] POKE_ADDR = 8'hf0;

  logic        clk_i = 1'b0;
  logic        rst_ni = 1'b0;
  cfg_req_t    cfg_req = '0;
  mem_req_t    host_mem = '0;
  logic [31:0] cfg_rdata;
  logic [31:0] host_rdata;
  logic        busy;
  logic        done;
  job_t        jobs [N_JOBS];
  logic [31:0] lcg_state = 32'h36fa_e489;
  int          done_cnt = 0;
  bit          verdict_given = 1'b0;

  always #20 clk_i = ~clk_i;

  acc_top i_acc_top (
    .clk_i, .rst_ni, .cfg_req_i(cfg_req), .cfg_rdata_o(cfg_rdata),
    .host_mem_i(host_mem), .host_rdata_o(host_rdata), .busy_o(busy), .done_o(done)
  );

  always @(negedge clk_i) if (done) done_cnt <= done_cnt + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] sentinel(logic [7:0] addr);
    return {8'h5e, addr, ~addr, addr ^ 8'h3c};
  endfunction

  // int8 x int8, times mult, arithmetic shift, plus add, clamp to int8
  function automatic logic [31:0] requant_ref(logic [7:0] a, logic [7:0] b, job_t j);
    longint v;
    v = longint'($signed(a)) * longint'($signed(b)) * longint'($signed(j.mult));
    v = v >>> j.shift;
    v = v + longint'($signed(j.add));
    if (v > 127) v = 127;
    else if (v < -128) v = -128;
    return v[31:0];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      verdict_given = 1'b1;
      $display(">>> FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic cfg_write(input int idx, input logic [31:0] data);
    @(posedge clk_i);
    cfg_req <= '{valid: 1'b1, we: 1'b1, addr: REG_AW'(idx), wdata: data};
    @(posedge clk_i);
    cfg_req <= '0;
  endtask

  task automatic cfg_read(input int idx, output logic [31:0] data);
    @(posedge clk_i);
    cfg_req <= '{valid: 1'b1, we: 1'b0, addr: REG_AW'(idx), wdata: '0};
    @(posedge clk_i);
    cfg_req <= '0;
    @(negedge clk_i);
    data = cfg_rdata;
  endtask

  task automatic mem_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    host_mem <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(posedge clk_i);
    host_mem <= '0;
  endtask

  task automatic mem_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    host_mem <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    @(posedge clk_i);
    host_mem <= '0;
    @(negedge clk_i);
    data = host_rdata; // Qualified by the host rvalid
  endtask

  initial begin
    logic [31:0] in_v [16];
    logic [31:0] w0_v [16];
    logic [31:0] w1_v [16];
    logic [31:0] regv [N_CFG_REGS];
    logic [31:0] rd;
    logic [31:0] exp;
    logic [7:0]  a;
    job_t        j;
    int          n;

    //          in     w0     w1     out    len    mult   shift  add    nl    od    poke
    jobs[0] = '{8'h00, 8'h20, 8'h40, 8'h80, 8'd8,  8'h03, 8'h02, 8'h05, 1'b0, 1'b0, 1'b0};
    jobs[1] = '{8'h00, 8'h20, 8'h40, 8'h80, 8'd8,  8'h7f, 8'h00, 8'h7f, 1'b0, 1'b0, 1'b0};
    jobs[2] = '{8'h08, 8'h28, 8'h48, 8'ha0, 8'd8,  8'h80, 8'h01, 8'h80, 1'b0, 1'b0, 1'b0};
    jobs[3] = '{8'h10, 8'h30, 8'h50, 8'h90, 8'd6,  8'h05, 8'h03, 8'hfe, 1'b1, 1'b0, 1'b0};
    jobs[4] = '{8'h00, 8'h20, 8'h40, 8'h80, 8'd5,  8'h03, 8'h02, 8'h05, 1'b0, 1'b1, 1'b0};
    jobs[5] = '{8'h18, 8'h38, 8'h58, 8'hc0, 8'd10, 8'h0b, 8'h04, 8'h03, 1'b1, 1'b0, 1'b1};

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int k = 0; k < N_JOBS; k++) begin
      j = jobs[k];
      n = int'(j.len);
      for (int i = 0; i < n; i++) begin
        in_v[i] = lcg_next();
        w0_v[i] = lcg_next();
        w1_v[i] = lcg_next();
        mem_write(j.in_ptr + 8'(i), in_v[i]);
        mem_write(j.w_ptr0 + 8'(i), w0_v[i]);
        mem_write(j.w_ptr1 + 8'(i), w1_v[i]);
      end
      for (int i = 0; i < 2 * n; i++) begin
        a = j.out_ptr + 8'(i);
        mem_write(a, sentinel(a)); // Both output halves
      end

      regv[REG_INPUT_PTR]   = {24'h0, j.in_ptr};
      regv[REG_WEIGHT_PTR0] = {24'h0, j.w_ptr0};
      regv[REG_WEIGHT_PTR1] = {24'h0, j.w_ptr1};
      regv[REG_OUTPUT_PTR]  = {24'h0, j.out_ptr};
      regv[REG_LEN]         = {24'h0, j.len};
      regv[REG_REQUANT]     = {8'h0, j.add, j.shift, j.mult};
      regv[REG_CTRL]        = {30'h0, j.out_disable, j.nextload};
      for (int r = 0; r < N_CFG_REGS; r++) cfg_write(r, regv[r]);
      for (int r = 0; r < N_CFG_REGS; r++) begin
        cfg_read(r, rd);
        check($sformatf("cfg_rdata_o[reg %0d]", r), rd, regv[r]);
      end

      cfg_write(REG_TRIGGER, 32'h1);
      if (j.poke) begin
        cfg_read(REG_STATUS, rd);
        check("cfg_rdata_o[status]", rd, 32'h1);
        cfg_write(REG_TRIGGER, 32'h1); // Busy, so no second job
        mem_write(POKE_ADDR, 32'hc0de_0000 | 32'(k));
      end
      do @(negedge clk_i); while (!done);
      @(negedge clk_i);
      check("busy_o", {31'h0, busy}, 32'h0);

      for (int i = 0; i < 2 * n; i++) begin
        a = j.out_ptr + 8'(i);
        if (j.out_disable || (i >= n && !j.nextload)) exp = sentinel(a);
        else if (i < n) exp = requant_ref(in_v[i][7:0], w0_v[i][7:0], j);
        else exp = requant_ref(in_v[i-n][7:0], w1_v[i-n][7:0], j);
        mem_read(a, rd);
        check($sformatf("host_rdata_o[0x%02h]", a), rd, exp);
      end
      if (j.poke) begin
        mem_read(POKE_ADDR, rd);
        check("host_rdata_o[poke]", rd, 32'hc0de_0000 | 32'(k));
      end
      check("done_o count", 32'(done_cnt), 32'(k + 1));
    end

    verdict_given = 1'b1;
    $display(">>> PASS");
    $finish;
  end

  // Budget of 200 cycles per processed element
  initial begin
    int limit;
    @(posedge rst_ni);
    limit = 0;
    for (int k = 0; k < N_JOBS; k++) begin
      limit += 200 * int'(jobs[k].len) * (jobs[k].nextload ? 2 : 1);
    end
    repeat (limit) @(posedge clk_i);
    verdict_given = 1'b1;
    $display("Timeout: the jobs did not finish within %0d cycles", limit);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  final begin
    if (!verdict_given) $display(">>> FAIL");
  end

endmodule

/* sources.f */
common/acc_pkg.sv
design/ctrl/acc_regfile.sv
design/ctrl/acc_ctrl.sv
design/stream/stream_source.sv
design/mem_arbiter.sv
design/scratch_mem.sv
design/requant_engine.sv
design/acc_top.sv
testbench/acc_props.sv
testbench/acc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -f sources.f --top-module acc_tb \
  --Mdir obj_dir -o acc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/acc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
